// ==== verilog/fpuPkg.sv ====
/*
 double-precision format constants for the multiplier
 and the rounding-mode encoding written through the control register
*/
`default_nettype none

package fpuPkg;

	// binary64 field widths
	localparam int expWidth = 11;
	localparam int fracWidth = 52;

	// exponent bias and the all-ones field
	localparam int expBias = 1023;
	localparam int expMax = 2047;

	// full 53x53 significand product
	localparam int productWidth = 106;

	// signed exponent sum, wide enough for 2*2047-1023 and for negatives
	localparam int expSumWidth = 13;

	// rounding modes, unknown codes fall back to nearest
	typedef enum logic [2:0]
	{
		rmNearest = 3'd0,
		rmTowardZero = 3'd1,
		rmUp = 3'd2,
		rmDown = 3'd3,
		rmOdd = 3'd4
	} roundMode_t;

endpackage

`default_nettype wire

// ==== verilog/busPkg.sv ====
/*
 wishbone slave widths, the word register map
 and the status register bit layout
*/
`default_nettype none

package busPkg;

	// word address and data widths
	localparam int wbAddrWidth = 3;
	localparam int wbDataWidth = 32;

	// register map, one 32-bit word each
	typedef enum logic [wbAddrWidth-1:0]
	{
		regOpALo = 3'd0,
		regOpAHi = 3'd1,
		regOpBLo = 3'd2,
		regOpBHi = 3'd3,
		regControl = 3'd4,
		regStatus = 3'd5,
		regResultLo = 3'd6,
		regResultHi = 3'd7
	} regAddr_t;

	// status word bits
	localparam int statusBusyBit = 0;
	localparam int statusDoneBit = 1;
	localparam int statusInexactBit = 2;

endpackage

`default_nettype wire

// ==== verilog/fpuMulSignExp.sv ====
/*
 sign and exponent side of the multiplier
 forms the product sign, biased exponent sum and zero flag,
 then delays them with the mode to line up with the mantissa path
*/
`timescale 1ns/100ps
`default_nettype none

module fpuMulSignExp
(
	input logic clock,
	input logic reset,
	input logic launch,
	input logic signA,
	input logic signB,
	input logic [fpuPkg::expWidth-1:0] expA,
	input logic [fpuPkg::expWidth-1:0] expB,
	input fpuPkg::roundMode_t roundMode,
	output logic valid,
	output logic sign,
	output logic signed [fpuPkg::expSumWidth-1:0] expSum,
	output logic zeroIn,
	output fpuPkg::roundMode_t mode
);

	import fpuPkg::*;

	localparam int depth = 3;

	// stage 0 is the first register, depth-1 drives the outputs
	logic validPipe [depth];
	logic signPipe [depth];
	logic signed [expSumWidth-1:0] expPipe [depth];
	logic zeroPipe [depth];
	roundMode_t modePipe [depth];

	logic signed [expSumWidth-1:0] expBiased;

	// zero-extend both fields before removing the bias
	assign expBiased = $signed({2'b00, expA}) + $signed({2'b00, expB})
		- $signed(expSumWidth'(expBias));

	// valid bits are control state
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < depth; i++)
				validPipe[i] <= 1'b0;
		end
		else
		begin
			validPipe[0] <= launch;
			for (int i = 1; i < depth; i++)
				validPipe[i] <= validPipe[i-1];
		end
	end

	// payload just shifts along
	always_ff @(posedge clock)
	begin
		signPipe[0] <= signA ^ signB;
		expPipe[0] <= expBiased;
		// subnormals flush, so a zero field means a zero operand
		zeroPipe[0] <= (expA == '0) || (expB == '0);
		modePipe[0] <= roundMode;
		for (int i = 1; i < depth; i++)
		begin
			signPipe[i] <= signPipe[i-1];
			expPipe[i] <= expPipe[i-1];
			zeroPipe[i] <= zeroPipe[i-1];
			modePipe[i] <= modePipe[i-1];
		end
	end

	assign valid = validPipe[depth-1];
	assign sign = signPipe[depth-1];
	assign expSum = expPipe[depth-1];
	assign zeroIn = zeroPipe[depth-1];
	assign mode = modePipe[depth-1];

endmodule

`default_nettype wire

// ==== verilog/fpuMulMantissa.sv ====
/*
 53x53 significand multiplier in three register stages
 18-bit limb products, then column-weight partial sums, then the full sum
*/
`timescale 1ns/100ps
`default_nettype none

module fpuMulMantissa
(
	input logic clock,
	input logic reset,
	input logic [fpuPkg::fracWidth-1:0] fracA,
	input logic [fpuPkg::fracWidth-1:0] fracB,
	output logic [fpuPkg::productWidth-1:0] product
);

	import fpuPkg::*;

	localparam int limbWidth = 18;
	localparam int limbCount = 3;
	localparam int sumWidth = 56;

	// significands padded to three full limbs
	logic [limbWidth*limbCount-1:0] sigA;
	logic [limbWidth*limbCount-1:0] sigB;

	// stage 1, nine limb products
	logic [2*limbWidth-1:0] partProd [limbCount][limbCount];

	// stage 2, grouped by column weight
	logic [sumWidth-1:0] sumLow;
	logic [sumWidth-1:0] sumMid;
	logic [sumWidth-1:0] sumHigh;

	logic [productWidth-1:0] productReg;

	// hidden one is implicit, top pad bit stays zero
	assign sigA = {1'b0, 1'b1, fracA};
	assign sigB = {1'b0, 1'b1, fracB};

	// no valid here, the sign/exp path carries it
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < limbCount; i++)
		begin
			for (int j = 0; j < limbCount; j++)
			begin
				partProd[i][j] <= sigA[i*limbWidth +: limbWidth]
					* sigB[j*limbWidth +: limbWidth];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		// weights 0 and 18
		sumLow <= sumWidth'(partProd[0][0])
			+ (sumWidth'(partProd[0][1]) << limbWidth)
			+ (sumWidth'(partProd[1][0]) << limbWidth);
		// weight 36
		sumMid <= sumWidth'(partProd[0][2])
			+ sumWidth'(partProd[1][1])
			+ sumWidth'(partProd[2][0]);
		// weights 54 and 72, kept relative to 54
		sumHigh <= sumWidth'(partProd[1][2])
			+ sumWidth'(partProd[2][1])
			+ (sumWidth'(partProd[2][2]) << limbWidth);
	end

	// 53x53 always fits in 106 bits
	always_ff @(posedge clock)
	begin
		productReg <= productWidth'(sumLow)
			+ (productWidth'(sumMid) << (2*limbWidth))
			+ (productWidth'(sumHigh) << (3*limbWidth));
	end

	assign product = productReg;

endmodule

`default_nettype wire

// ==== verilog/fpuMulRound.sv ====
/*
 normalize, round and pack the multiplier result
 handles carry into the exponent, overflow to infinity
 and underflow to zero, one register stage
*/
`timescale 1ns/100ps
`default_nettype none

module fpuMulRound
(
	input logic clock,
	input logic reset,
	input logic valid,
	input logic sign,
	input logic signed [fpuPkg::expSumWidth-1:0] expSum,
	input logic zeroIn,
	input fpuPkg::roundMode_t mode,
	input logic [fpuPkg::productWidth-1:0] product,
	output logic [63:0] result,
	output logic inexact,
	output logic resultValid
);

	import fpuPkg::*;

	logic normShift;
	logic [fracWidth-1:0] keptFrac;
	logic guardBit;
	logic sticky;
	logic roundInc;
	logic [fracWidth:0] fracSum;
	logic carryOut;
	logic [fracWidth-1:0] fracOut;
	logic signed [expSumWidth:0] expNorm;
	logic signed [expSumWidth:0] expFinal;
	logic [63:0] packedResult;
	logic packedInexact;

	// product in [1,4), top bit picks the shift
	assign normShift = product[productWidth-1];

	always_comb
	begin
		if (normShift)
		begin
			keptFrac = product[104:53];
			guardBit = product[52];
			sticky = |product[52:0];
		end
		else
		begin
			keptFrac = product[103:52];
			guardBit = product[51];
			sticky = |product[51:0];
		end
	end

	// increment per mode
	always_comb
	begin
		case (mode)
			rmTowardZero: roundInc = 1'b0;
			rmUp: roundInc = sticky && !sign;
			rmDown: roundInc = sticky && sign;
			rmOdd: roundInc = 1'b0;
			// ties away, so the guard bit alone decides
			default: roundInc = guardBit;
		endcase
	end

	assign fracSum = {1'b0, keptFrac} + {{fracWidth{1'b0}}, roundInc};
	assign carryOut = fracSum[fracWidth];

	always_comb
	begin
		fracOut = fracSum[fracWidth-1:0];
		// round-to-odd sticks the lsb
		if ((mode == rmOdd) && sticky)
			fracOut[0] = 1'b1;
	end

	assign expNorm = expSum + $signed({{expSumWidth{1'b0}}, normShift});
	assign expFinal = expNorm + $signed({{expSumWidth{1'b0}}, carryOut});

	always_comb
	begin
		if (zeroIn)
		begin
			// flushed input, exact zero
			packedResult = '0;
			packedInexact = 1'b0;
		end
		else if (expFinal >= expMax)
		begin
			// overflow to infinity, keep the sign
			packedResult = {sign, expWidth'(expMax), {fracWidth{1'b0}}};
			packedInexact = 1'b1;
		end
		else if (expFinal <= 0)
		begin
			packedResult = '0;
			packedInexact = 1'b1;
		end
		else
		begin
			packedResult = {sign, expFinal[expWidth-1:0], fracOut};
			packedInexact = sticky;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= valid;
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		result <= packedResult;
		inexact <= packedInexact;
	end

endmodule

`default_nettype wire

// ==== verilog/fpuMulRegs.sv ====
/*
 wishbone classic slave for the multiplier
 operand, control, status and result registers,
 one-cycle ack and a launch pulse on every control write
*/
`timescale 1ns/100ps
`default_nettype none

module fpuMulRegs
(
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input busPkg::regAddr_t adr,
	input logic [busPkg::wbDataWidth-1:0] datIn,
	output logic [busPkg::wbDataWidth-1:0] datOut,
	output logic ack,
	output logic [63:0] opA,
	output logic [63:0] opB,
	output fpuPkg::roundMode_t roundMode,
	output logic launch,
	input logic [63:0] result,
	input logic inexact,
	input logic resultValid
);

	import busPkg::*;
	import fpuPkg::*;

	logic accept;
	logic busWrite;
	logic ctrlWrite;
	logic busy;
	logic done;
	// up to four in flight fits in three bits
	logic [2:0] pending;
	logic [63:0] resultReg;
	logic inexactReg;
	logic [wbDataWidth-1:0] statusWord;
	logic [wbDataWidth-1:0] readData;

	// new cycle only while ack is low
	assign accept = cyc && stb && !ack;
	assign busWrite = accept && we;
	assign ctrlWrite = busWrite && (adr == regControl);
	assign busy = (pending != 3'd0);

	always_comb
	begin
		statusWord = '0;
		statusWord[statusBusyBit] = busy;
		statusWord[statusDoneBit] = done;
		statusWord[statusInexactBit] = inexactReg;
	end

	// read mux
	always_comb
	begin
		case (adr)
			regOpALo: readData = opA[31:0];
			regOpAHi: readData = opA[63:32];
			regOpBLo: readData = opB[31:0];
			regOpBHi: readData = opB[63:32];
			regControl: readData = {{(wbDataWidth-3){1'b0}}, roundMode};
			regStatus: readData = statusWord;
			regResultLo: readData = resultReg[31:0];
			default: readData = resultReg[63:32];
		endcase
	end

	// bus side, ack and read data land on the same edge
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			datOut <= '0;
			launch <= 1'b0;
			opA <= '0;
			opB <= '0;
			roundMode <= rmNearest;
		end
		else
		begin
			ack <= accept;
			launch <= ctrlWrite;
			if (accept)
				datOut <= readData;
			if (busWrite)
			begin
				case (adr)
					regOpALo: opA[31:0] <= datIn;
					regOpAHi: opA[63:32] <= datIn;
					regOpBLo: opB[31:0] <= datIn;
					regOpBHi: opB[63:32] <= datIn;
					regControl: roundMode <= roundMode_t'(datIn[2:0]);
					// status and result are read only
					default: ;
				endcase
			end
		end
	end

	// outstanding launches, done and the latched result
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pending <= 3'd0;
			done <= 1'b0;
			resultReg <= '0;
			inexactReg <= 1'b0;
		end
		else
		begin
			if (ctrlWrite && !resultValid)
				pending <= pending + 3'd1;
			else if (!ctrlWrite && resultValid)
				pending <= pending - 3'd1;

			// results come back in launch order
			if (resultValid)
			begin
				resultReg <= result;
				inexactReg <= inexact;
			end

			// done only once the newest launch has returned
			if (ctrlWrite)
				done <= 1'b0;
			else if (resultValid && (pending == 3'd1))
				done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fpuMulTop.sv ====
/*
 multiplier top level
 register block feeding the sign/exp and mantissa paths,
 both merged by the rounding stage
*/
`timescale 1ns/100ps
`default_nettype none

module fpuMulTop
(
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input busPkg::regAddr_t adr,
	input logic [busPkg::wbDataWidth-1:0] datIn,
	output logic [busPkg::wbDataWidth-1:0] datOut,
	output logic ack
);

	import fpuPkg::*;

	// register block to datapath
	logic [63:0] opA;
	logic [63:0] opB;
	roundMode_t roundMode;
	logic launch;

	// sign/exp path to rounding
	logic valid;
	logic sign;
	logic signed [expSumWidth-1:0] expSum;
	logic zeroIn;
	roundMode_t mode;

	// mantissa path to rounding
	logic [productWidth-1:0] product;

	// rounding back to the register block
	logic [63:0] result;
	logic inexact;
	logic resultValid;

	fpuMulRegs regs
	(
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.opA(opA),
		.opB(opB),
		.roundMode(roundMode),
		.launch(launch),
		.result(result),
		.inexact(inexact),
		.resultValid(resultValid)
	);

	// operand fields split as sign, exponent, fraction
	fpuMulSignExp signExp
	(
		.clock(clock),
		.reset(reset),
		.launch(launch),
		.signA(opA[63]),
		.signB(opB[63]),
		.expA(opA[62:52]),
		.expB(opB[62:52]),
		.roundMode(roundMode),
		.valid(valid),
		.sign(sign),
		.expSum(expSum),
		.zeroIn(zeroIn),
		.mode(mode)
	);

	fpuMulMantissa mantissa
	(
		.clock(clock),
		.reset(reset),
		.fracA(opA[51:0]),
		.fracB(opB[51:0]),
		.product(product)
	);

	fpuMulRound round
	(
		.clock(clock),
		.reset(reset),
		.valid(valid),
		.sign(sign),
		.expSum(expSum),
		.zeroIn(zeroIn),
		.mode(mode),
		.product(product),
		.result(result),
		.inexact(inexact),
		.resultValid(resultValid)
	);

endmodule

`default_nettype wire

// ==== test/fpuMulModel.svh ====
/*
 reference model for the double-precision multiplier
 flush-to-zero inputs, five rounding modes, full-width product
*/
`ifndef FPU_MUL_MODEL_SVH
`define FPU_MUL_MODEL_SVH

// returns {inexact, result}
function automatic logic [64:0] fpMulRef(input logic [63:0] a, input logic [63:0] b,
	input logic [2:0] mode);
	logic [105:0] sigA;
	logic [105:0] sigB;
	logic [105:0] prod;
	logic [105:0] shifted;
	logic [105:0] droppedMask;
	logic [52:0] frac;
	logic [10:0] expField;
	logic sign;
	logic lost;
	logic half;
	logic inc;
	int shift;
	int e;
	sign = a[63] ^ b[63];
	// exponent field 0 counts as zero
	if ((a[62:52] == 11'd0) || (b[62:52] == 11'd0))
		return {1'b0, 64'd0};
	e = int'(a[62:52]) + int'(b[62:52]) - expBias;
	sigA = {53'd0, 1'b1, a[51:0]};
	sigB = {53'd0, 1'b1, b[51:0]};
	prod = sigA * sigB;
	// product in [1,4), one extra bit to drop when >= 2
	shift = prod[105] ? 53 : 52;
	e = e + (shift - 52);
	droppedMask = (106'd1 << shift) - 106'd1;
	lost = ((prod & droppedMask) != 106'd0);
	half = prod[shift-1];
	shifted = prod >> shift;
	frac = {1'b0, shifted[51:0]};
	case (mode)
		rmTowardZero: inc = 1'b0;
		rmUp: inc = lost && !sign;
		rmDown: inc = lost && sign;
		rmOdd: inc = 1'b0;
		default: inc = half;
	endcase
	frac = frac + {52'd0, inc};
	// carry out of the fraction
	if (frac[52])
	begin
		frac = 53'd0;
		e = e + 1;
	end
	if ((mode == rmOdd) && lost)
		frac[0] = 1'b1;
	if (e >= expMax)
		return {1'b1, sign, 11'h7ff, 52'd0};
	if (e <= 0)
		return {1'b1, 64'd0};
	expField = e[10:0];
	return {lost, sign, expField, frac[51:0]};
endfunction

`endif

// ==== test/fpuMulTb.sv ====
/*
 testbench for the wishbone double-precision multiplier
 drives register accesses, compares results against the reference model
*/
`timescale 1ns/100ps
`default_nettype none

module fpuMulTb;

	import busPkg::*;
	import fpuPkg::*;

	localparam int clockPeriod = 4;
	localparam int resetCycles = 5;
	localparam int ackLimit = 8;
	localparam int pollLimit = 20;
	localparam int cyclesPerOp = 40;
	// operation counts per test group
	localparam int readbackOps = 2;
	localparam int exactOps = 15;
	localparam int randomOps = 40;
	localparam int cornerOps = 5;
	localparam int carryOps = 2;
	localparam int chainOps = 3;
	localparam int totalOps = readbackOps + exactOps + randomOps + cornerOps
		+ carryOps + chainOps;

	logic clock;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	regAddr_t adr;
	logic [31:0] datIn;
	logic [31:0] datOut;
	logic ack;

	int errors;
	int checks;
	int seedValue;
	int polls;
	logic [31:0] rd;
	logic [31:0] lo;
	logic [31:0] hi;
	logic [63:0] opA;
	logic [63:0] opB;
	logic [64:0] expected;
	logic [2:0] mode3;

	// expected and observed results, in launch order
	logic [64:0] expQ [$];
	logic [64:0] gotQ [$];
	string tagQ [$];
	logic [64:0] cmpExp;
	logic [64:0] cmpGot;
	string cmpTag;

	fpuMulTop uut
	(
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	`include "fpuMulModel.svh"

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod/2) clock = ~clock;
	end

	task automatic checkValue(input string what, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		if (got !== want)
		begin
			$display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	// one classic cycle, inputs change 1 ns after the edge
	task automatic wbWrite(input regAddr_t addr, input logic [31:0] data);
		int waitCycles;
		waitCycles = 0;
		@(posedge clock);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = addr;
		datIn = data;
		@(posedge clock);
		#1;
		while (!ack && (waitCycles < ackLimit))
		begin
			@(posedge clock);
			#1;
			waitCycles++;
		end
		if (!ack)
		begin
			$display("bus error: write to register %0d was never acknowledged", addr);
			errors++;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbRead(input regAddr_t addr, output logic [31:0] data);
		int waitCycles;
		waitCycles = 0;
		@(posedge clock);
		#1;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = addr;
		@(posedge clock);
		#1;
		while (!ack && (waitCycles < ackLimit))
		begin
			@(posedge clock);
			#1;
			waitCycles++;
		end
		if (!ack)
		begin
			$display("bus error: read of register %0d was never acknowledged", addr);
			errors++;
		end
		// read data is valid while ack is high
		data = datOut;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic loadOperands(input logic [63:0] a, input logic [63:0] b);
		wbWrite(regOpALo, a[31:0]);
		wbWrite(regOpAHi, a[63:32]);
		wbWrite(regOpBLo, b[31:0]);
		wbWrite(regOpBHi, b[63:32]);
	endtask

	// poll status, then queue the result for the compare process
	task automatic collectResult(input string tag, input logic [64:0] want);
		logic [31:0] status;
		logic [31:0] resLo;
		logic [31:0] resHi;
		int n;
		n = 0;
		wbRead(regStatus, status);
		while (!status[statusDoneBit] && (n < pollLimit))
		begin
			wbRead(regStatus, status);
			n++;
		end
		if (!status[statusDoneBit])
		begin
			$display("%s: done never set within %0d status reads", tag, pollLimit);
			errors++;
		end
		checkValue($sformatf("%s busy", tag), {63'd0, status[statusBusyBit]}, 64'd0);
		wbRead(regResultLo, resLo);
		wbRead(regResultHi, resHi);
		expQ.push_back(want);
		tagQ.push_back(tag);
		gotQ.push_back({status[statusInexactBit], resHi, resLo});
	endtask

	task automatic runOp(input logic [63:0] a, input logic [63:0] b, input logic [2:0] mode,
		input string tag, input logic [64:0] want);
		loadOperands(a, b);
		// control write launches the multiply
		wbWrite(regControl, {29'd0, mode});
		collectResult(tag, want);
	endtask

	// normal operand, exponent kept near the bias
	function automatic logic [63:0] randomNormal();
		logic [63:0] bits;
		logic [10:0] e;
		int pick;
		bits = {$urandom(), $urandom()};
		pick = 823 + ($urandom() % 400);
		e = pick[10:0];
		return {bits[63], e, bits[51:0]};
	endfunction

	// compare process
	initial
	begin
		forever
		begin
			@(posedge clock);
			while (gotQ.size() > 0)
			begin
				cmpExp = expQ.pop_front();
				cmpGot = gotQ.pop_front();
				cmpTag = tagQ.pop_front();
				checkValue($sformatf("%s result", cmpTag), cmpGot[63:0], cmpExp[63:0]);
				checkValue($sformatf("%s inexact", cmpTag), {63'd0, cmpGot[64]},
					{63'd0, cmpExp[64]});
			end
		end
	end

	// watchdog, budget scales with the operation count
	initial
	begin
		#((resetCycles + totalOps * cyclesPerOp) * clockPeriod);
		$display("watchdog expired before all operations finished");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = regOpALo;
		datIn = 32'd0;
		reset = 1'b1;
		errors = 0;
		checks = 0;
		seedValue = $urandom(56);
		repeat (resetCycles) @(posedge clock);
		#1;
		reset = 1'b0;

		// register readback
		wbRead(regStatus, rd);
		checkValue("status after reset", {32'd0, rd}, 64'd0);
		loadOperands(64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210);
		wbRead(regOpALo, rd);
		checkValue("opA low readback", {32'd0, rd}, 64'h89ab_cdef);
		wbRead(regOpAHi, rd);
		checkValue("opA high readback", {32'd0, rd}, 64'h0123_4567);
		wbRead(regOpBLo, rd);
		checkValue("opB low readback", {32'd0, rd}, 64'h7654_3210);
		wbRead(regOpBHi, rd);
		checkValue("opB high readback", {32'd0, rd}, 64'hfedc_ba98);

		// exact products in every mode
		for (int m = 0; m < 5; m++)
		begin
			mode3 = m[2:0];
			runOp(64'h3ff8_0000_0000_0000, 64'h4000_0000_0000_0000, mode3,
				$sformatf("1.5*2.0 mode %0d", m), {1'b0, 64'h4008_0000_0000_0000});
			runOp(64'hc008_0000_0000_0000, 64'h3fd0_0000_0000_0000, mode3,
				$sformatf("-3.0*0.25 mode %0d", m), {1'b0, 64'hbfe8_0000_0000_0000});
			runOp(64'h3ff4_0000_0000_0000, 64'h3ff4_0000_0000_0000, mode3,
				$sformatf("1.25*1.25 mode %0d", m), {1'b0, 64'h3ff9_0000_0000_0000});
		end

		// random normal operands, modes in rotation
		for (int i = 0; i < randomOps; i++)
		begin
			opA = randomNormal();
			opB = randomNormal();
			mode3 = 3'(i % 5);
			runOp(opA, opB, mode3, $sformatf("random %0d", i), fpMulRef(opA, opB, mode3));
		end

		// flushed zero, overflow, underflow
		runOp(64'h000f_ffff_ffff_ffff, 64'h4000_0000_0000_0000, rmNearest,
			"zero exponent A", {1'b0, 64'd0});
		runOp(64'hc008_0000_0000_0000, 64'h8000_0000_0000_0000, rmUp,
			"zero exponent B", {1'b0, 64'd0});
		runOp(64'h7e78_0000_0000_0000, 64'h7e78_0000_0000_0000, rmTowardZero,
			"overflow positive", {1'b1, 64'h7ff0_0000_0000_0000});
		runOp(64'hfe78_0000_0000_0000, 64'h7e78_0000_0000_0000, rmNearest,
			"overflow negative", {1'b1, 64'hfff0_0000_0000_0000});
		runOp(64'h8640_0000_0000_0000, 64'h0648_0000_0000_0000, rmDown,
			"underflow", {1'b1, 64'd0});

		// product just under 2.0, kept fraction all ones, rounding carries
		opA = 64'h3fff_ffff_ffff_fffe;
		opB = 64'h3ff0_0000_0000_0001;
		expected = fpMulRef(opA, opB, rmUp);
		checkValue("reference carry value", expected[63:0], 64'h4000_0000_0000_0000);
		runOp(opA, opB, rmUp, "carry up", expected);
		runOp(opA, opB, rmNearest, "carry nearest", fpMulRef(opA, opB, rmNearest));

		// three launches in a row, last mode wins
		opA = 64'h3ff5_5555_5555_5555;
		opB = 64'h4008_0000_0000_0001;
		loadOperands(opA, opB);
		wbWrite(regControl, {29'd0, rmDown});
		wbWrite(regControl, {29'd0, rmTowardZero});
		wbWrite(regControl, {29'd0, rmUp});
		polls = 0;
		wbRead(regStatus, rd);
		while (!rd[statusDoneBit] && (polls < pollLimit))
		begin
			checkValue("busy while launches pending", {63'd0, rd[statusBusyBit]}, 64'd1);
			wbRead(regStatus, rd);
			polls++;
		end
		if (!rd[statusDoneBit])
		begin
			$display("chained launches: done never set within %0d status reads", pollLimit);
			errors++;
		end
		checkValue("busy after chain done", {63'd0, rd[statusBusyBit]}, 64'd0);
		wbRead(regResultLo, lo);
		wbRead(regResultHi, hi);
		expQ.push_back(fpMulRef(opA, opB, rmUp));
		tagQ.push_back("chained launches");
		gotQ.push_back({rd[statusInexactBit], hi, lo});
		// control register returns the last mode written
		wbRead(regControl, rd);
		checkValue("control readback", {32'd0, rd}, {61'd0, rmUp});

		// let the compare process drain
		while (gotQ.size() > 0)
			@(posedge clock);
		repeat (2) @(posedge clock);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+test
verilog/fpuPkg.sv
verilog/busPkg.sv
verilog/fpuMulSignExp.sv
verilog/fpuMulMantissa.sv
verilog/fpuMulRound.sv
verilog/fpuMulRegs.sv
verilog/fpuMulTop.sv
test/fpuMulTb.sv
